// File: sources.f
+incdir+test
src/ctrlPkg.sv
src/specialDecode.sv
src/regimmDecode.sv
src/memOpDecode.sv
src/mainDecode.sv
src/controlUnit.sv
test/tb_controlUnit.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_controlUnit -o simControl
./obj_dir/simControl | tee sim.log

if grep -q "tests failed" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

// File: test/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// expected outputs packed in DUT port order
function automatic logic [31:0] expectedControls(input logic [31:0] word);
	instrWord_u w;
	logic rsR, rtR, ovf, br, lnk, jmp, m2r, selAS, srcA, srcB, amtSrc, known;
	logic [1:0] ext, dst, sh;
	logic [2:0] cond;
	logic [3:0] memWe, regWe, alu;
	w = word;
	{rsR, rtR, ovf, br, lnk, jmp, m2r, selAS, srcA, srcB, amtSrc, known} = '0;
	{ext, dst, sh, cond, memWe, regWe, alu} = '0;
	case (w.iFormat.op)
		OP_SPECIAL: begin
			known = 1'b1;
			case (w.rFormat.func)
				FN_ADD:  {rsR, selAS, ovf, alu} = {3'b111, ALU_ADD};
				FN_SUB:  {rsR, selAS, ovf, alu} = {3'b111, ALU_SUB};
				FN_SUBU: {rsR, selAS, alu} = {2'b11, ALU_SUBU};
				FN_XOR:  {rsR, selAS, alu} = {2'b11, ALU_XOR};
				FN_SLTU: {rsR, selAS, alu} = {2'b11, ALU_SLTU};
				FN_SRAV: {rsR, amtSrc, sh} = {2'b11, SHIFT_SRA};
				FN_ROTR: sh = SHIFT_ROTR; // shamt amount, rs unused
				default: known = 1'b0;
			endcase
			if (known) {rtR, regWe, dst} = {1'b1, BYTES_ALL, REGDST_RD};
		end
		OP_J: {jmp, selAS} = 2'b11;
		OP_REGIMM: begin
			known = 1'b1;
			case (w.iFormat.rt)
				RT_BLTZ:   {rtR, cond} = {1'b1, COND_LTZ};
				RT_BGEZ:   cond = COND_GEZ;
				RT_BGEZAL: {cond, lnk, regWe, dst} = {COND_GEZ, 1'b1, BYTES_ALL, REGDST_RA};
				default:   known = 1'b0;
			endcase
			if (known) {rsR, br, alu} = {2'b11, ALU_SUBU};
		end
		OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ: begin
			{rsR, rtR, br, alu} = {3'b111, ALU_SUBU};
			cond = (w.iFormat.op == OP_BEQ) ? COND_EQ :
				(w.iFormat.op == OP_BNE) ? COND_NE :
				(w.iFormat.op == OP_BGTZ) ? COND_GTZ : COND_LEZ;
		end
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_XORI: begin
			{rsR, selAS, srcB, regWe, dst} = {3'b111, BYTES_ALL, REGDST_RT};
			case (w.iFormat.op)
				OP_ADDI:  {alu, ovf} = {ALU_ADD, 1'b1};
				OP_ADDIU: alu = ALU_ADDU;
				OP_SLTI:  alu = ALU_SLT;
				default:  {alu, ext} = {ALU_XOR, EXT_ZERO};
			endcase
		end
		OP_LUI: {selAS, srcA, srcB, regWe, dst, alu, ext} =
			{3'b111, BYTES_ALL, REGDST_RT, ALU_ADDU, EXT_UPPER};
		OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
			{rsR, selAS, srcB, alu, m2r, dst} = {3'b111, ALU_ADDU, 1'b1, REGDST_RT};
			regWe = (w.iFormat.op == OP_LBU) ? BYTES_ONE :
				(w.iFormat.op == OP_LHU) ? BYTES_HALF : BYTES_ALL;
		end
		OP_SB, OP_SH, OP_SW: {rsR, rtR, selAS, srcB, alu, memWe} = {4'b1111, ALU_ADDU, BYTES_ALL};
		default: ; // undecoded word, all zero
	endcase
	return {rsR, rtR, ext, ovf, cond, br, lnk, jmp, memWe, regWe, m2r, selAS, srcA, srcB,
		alu, dst, amtSrc, sh};
endfunction

`endif

// File: test/tb_controlUnit.sv
`timescale 1ns/100ps

module tb_controlUnit import ctrlPkg::*; ();

	localparam int RESET_CYCLES = 8;
	localparam int DIRECTED_WORDS = 33;
	localparam int RANDOM_WORDS = 2048;
	// reset and every word plus margin
	localparam int CYCLE_LIMIT = (RESET_CYCLES + DIRECTED_WORDS + RANDOM_WORDS) * 9 / 8 + 48;

	logic clk = 1'b0;
	logic rst;
	instrWord_u instr;
	logic rsRead, rtRead, overflowEn, branch, branchLink, jump, memToReg;
	logic aluShiftSel, aluSrcA, aluSrcB, shiftAmtSrc;
	logic [1:0] extOp, regDst, shiftOp;
	logic [2:0] condition;
	logic [3:0] memWriteEn, regWriteEn, aluOp;
	logic [31:0] actVec, expVec;
	logic checkEn;
	string testName;
	integer seed;
	int cycles = 0, checks = 0, totalErrs = 0, testErrs = 0;
	int testsRun = 0, testsBad = 0, testWords = 0;

	logic [5:0] fnList [7] = '{FN_ADD, FN_SUB, FN_SUBU, FN_XOR, FN_SLTU, FN_SRAV, FN_ROTR};
	logic [5:0] immOps [5] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_XORI, OP_LUI};
	logic [5:0] brOps [5] = '{OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ, OP_J};
	logic [4:0] rtList [3] = '{RT_BLTZ, RT_BGEZ, RT_BGEZAL};
	logic [5:0] memOps [8] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};

`include "refModel.svh"

	controlUnit controlUnit_i (.*);

	assign actVec = {rsRead, rtRead, extOp, overflowEn, condition, branch, branchLink, jump,
		memWriteEn, regWriteEn, memToReg, aluShiftSel, aluSrcA, aluSrcB, aluOp, regDst,
		shiftAmtSrc, shiftOp};

	always #10 clk = ~clk;

	// instr driven on the falling edge and compared on the rising edge
	always @(posedge clk) begin
		if (rst || checkEn) begin
			expVec = expectedControls(instr);
			checks++;
			assert (actVec === expVec) else begin
				$display("MISMATCH %s expected %h actual %h (word %h)", testName, expVec,
					actVec, instr);
				testErrs++;
				totalErrs++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("tests failed");
			$finish;
		end
	end

	task automatic applyWord(input logic [31:0] w);
		@(negedge clk);
		instr = w;
		checkEn = 1'b1;
		testWords++;
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrs = 0;
		testWords = 0;
	endtask

	task automatic finishTest();
		@(negedge clk); // last word checked by now
		checkEn = 1'b0;
		testsRun++;
		if (testErrs != 0) testsBad++;
		$display("test %s done: %0d words, %0d mismatches", testName, testWords, testErrs);
	endtask

	initial begin
		seed = 32'h8570ecb6;
		rst = 1'b1;
		instr = '0; // decodes to all zero
		checkEn = 1'b0;
		testName = "reset";
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		startTest("rtype");
		foreach (fnList[i]) applyWord({OP_SPECIAL, 20'($random(seed)), fnList[i]});
		finishTest();

		startTest("immediate");
		foreach (immOps[i]) applyWord({immOps[i], 26'($random(seed))});
		finishTest();

		startTest("branch_jump");
		foreach (brOps[i]) applyWord({brOps[i], 26'($random(seed))});
		foreach (rtList[i]) begin
			applyWord({OP_REGIMM, 5'($random(seed)), rtList[i], 16'($random(seed))});
		end
		finishTest();

		startTest("load_store");
		foreach (memOps[i]) applyWord({memOps[i], 26'($random(seed))});
		finishTest();

		startTest("undefined");
		applyWord({OP_SPECIAL, 20'($random(seed)), 6'b111111}); // unknown func
		applyWord({OP_REGIMM, 5'($random(seed)), 5'd2, 16'($random(seed))});
		applyWord({6'b011100, 20'($random(seed)), 6'b100000}); // clz
		applyWord({6'b011111, 10'($random(seed)), 5'($random(seed)), 11'b10000100000}); // seb
		applyWord({6'b100010, 26'($random(seed))}); // lwl
		finishTest();

		startTest("random");
		repeat (RANDOM_WORDS) applyWord($random(seed));
		finishTest();

		$display("summary: %0d tests, %0d with errors, %0d checks, %0d mismatches",
			testsRun, testsBad, checks, totalErrs);
		if (totalErrs == 0 && testsBad == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: src/controlUnit.sv
`timescale 1ns/100ps

module controlUnit import ctrlPkg::*; (
	input  instrWord_u instr,
	output logic       rsRead,
	output logic       rtRead,
	output logic [1:0] extOp,
	output logic       overflowEn,
	output logic [2:0] condition,
	output logic       branch,
	output logic       branchLink,
	output logic       jump,
	output logic [3:0] memWriteEn,
	output logic [3:0] regWriteEn,
	output logic       memToReg,
	output logic       aluShiftSel,
	output logic       aluSrcA,
	output logic       aluSrcB,
	output logic [3:0] aluOp,
	output logic [1:0] regDst,
	output logic       shiftAmtSrc,
	output logic [1:0] shiftOp
);

	logic       spHit, spRsRead, spOverflowEn, spAluShiftSel, spShiftAmtSrc;
	logic [3:0] spAluOp;
	logic [1:0] spShiftOp;
	logic       riHit, riRtRead, riBranchLink, riLinkWrite;
	logic [2:0] riCondition;
	logic       moHit, moIsStore;
	logic [3:0] moRegWriteEn, moMemWriteEn;

	specialDecode specialDecode_i (.func(instr.rFormat.func), .hit(spHit), .rsRead(spRsRead),
		.overflowEn(spOverflowEn), .aluShiftSel(spAluShiftSel), .aluOp(spAluOp),
		.shiftAmtSrc(spShiftAmtSrc), .shiftOp(spShiftOp));
	regimmDecode regimmDecode_i (.rt(instr.iFormat.rt), .hit(riHit), .rtRead(riRtRead),
		.branchLink(riBranchLink), .condition(riCondition), .linkWrite(riLinkWrite));
	memOpDecode memOpDecode_i (.op(instr.iFormat.op), .hit(moHit), .isStore(moIsStore),
		.regWriteEn(moRegWriteEn), .memWriteEn(moMemWriteEn));

	mainDecode mainDecode_i (.op(instr.iFormat.op), .*);

endmodule

// File: src/mainDecode.sv
`timescale 1ns/100ps

module mainDecode import ctrlPkg::*; (
	input  logic [5:0] op,
	input  logic       spHit,
	input  logic       spRsRead,
	input  logic       spOverflowEn,
	input  logic       spAluShiftSel,
	input  logic [3:0] spAluOp,
	input  logic       spShiftAmtSrc,
	input  logic [1:0] spShiftOp,
	input  logic       riHit,
	input  logic       riRtRead,
	input  logic       riBranchLink,
	input  logic [2:0] riCondition,
	input  logic       riLinkWrite,
	input  logic       moHit,
	input  logic       moIsStore,
	input  logic [3:0] moRegWriteEn,
	input  logic [3:0] moMemWriteEn,
	output logic       rsRead,
	output logic       rtRead,
	output logic [1:0] extOp,
	output logic       overflowEn,
	output logic [2:0] condition,
	output logic       branch,
	output logic       branchLink,
	output logic       jump,
	output logic [3:0] memWriteEn,
	output logic [3:0] regWriteEn,
	output logic       memToReg,
	output logic       aluShiftSel,
	output logic       aluSrcA,
	output logic       aluSrcB,
	output logic [3:0] aluOp,
	output logic [1:0] regDst,
	output logic       shiftAmtSrc,
	output logic [1:0] shiftOp
);

	always_comb begin
		rsRead = 1'b0;
		rtRead = 1'b0;
		extOp = 2'b00;
		overflowEn = 1'b0;
		condition = 3'b000;
		branch = 1'b0;
		branchLink = 1'b0;
		jump = 1'b0;
		memWriteEn = 4'b0000;
		regWriteEn = 4'b0000;
		memToReg = 1'b0;
		aluShiftSel = 1'b0;
		aluSrcA = 1'b0;
		aluSrcB = 1'b0;
		aluOp = 4'b0000;
		regDst = 2'b00;
		shiftAmtSrc = 1'b0;
		shiftOp = 2'b00;
		case (op)
			OP_SPECIAL: if (spHit) begin
				rsRead = spRsRead;
				rtRead = 1'b1;
				regWriteEn = BYTES_ALL;
				regDst = REGDST_RD;
				overflowEn = spOverflowEn;
				aluShiftSel = spAluShiftSel;
				aluOp = spAluOp;
				shiftAmtSrc = spShiftAmtSrc;
				shiftOp = spShiftOp;
			end
			OP_J: begin
				jump = 1'b1;
				aluShiftSel = 1'b1;
			end
			OP_REGIMM: if (riHit) begin
				rsRead = 1'b1;
				rtRead = riRtRead;
				branch = 1'b1;
				branchLink = riBranchLink;
				condition = riCondition;
				aluOp = ALU_SUBU;
				if (riLinkWrite) begin
					regWriteEn = BYTES_ALL;
					regDst = REGDST_RA;
				end
			end
			OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ: begin
				rsRead = 1'b1;
				rtRead = 1'b1;
				branch = 1'b1;
				aluOp = ALU_SUBU;
				case (op)
					OP_BEQ:  condition = COND_EQ;
					OP_BNE:  condition = COND_NE;
					OP_BGTZ: condition = COND_GTZ;
					default: condition = COND_LEZ;
				endcase
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_XORI: begin
				rsRead = 1'b1;
				aluShiftSel = 1'b1;
				aluSrcB = 1'b1; // immediate operand
				regWriteEn = BYTES_ALL;
				regDst = REGDST_RT;
				extOp = EXT_SIGN;
				case (op)
					OP_ADDI: begin
						aluOp = ALU_ADD;
						overflowEn = 1'b1;
					end
					OP_ADDIU: aluOp = ALU_ADDU;
					OP_SLTI:  aluOp = ALU_SLT;
					default: begin
						aluOp = ALU_XOR;
						extOp = EXT_ZERO; // logical ops zero extend
					end
				endcase
			end
			OP_LUI: begin
				aluShiftSel = 1'b1;
				aluSrcA = 1'b1; // zero instead of rs
				aluSrcB = 1'b1;
				regWriteEn = BYTES_ALL;
				regDst = REGDST_RT;
				aluOp = ALU_ADDU;
				extOp = EXT_UPPER;
			end
			default: if (moHit) begin
				rsRead = 1'b1;
				aluShiftSel = 1'b1;
				aluSrcB = 1'b1; // base plus offset
				aluOp = ALU_ADDU;
				extOp = EXT_SIGN;
				regWriteEn = moRegWriteEn;
				memWriteEn = moMemWriteEn;
				if (moIsStore) begin
					rtRead = 1'b1;
				end else begin
					memToReg = 1'b1;
					regDst = REGDST_RT;
				end
			end
		endcase
	end

endmodule

// File: src/memOpDecode.sv
`timescale 1ns/100ps

module memOpDecode import ctrlPkg::*; (
	input  logic [5:0] op,
	output logic       hit,
	output logic       isStore,
	output logic [3:0] regWriteEn,
	output logic [3:0] memWriteEn
);

	always_comb begin
		hit = 1'b1;
		isStore = 1'b0;
		regWriteEn = BYTES_NONE;
		memWriteEn = BYTES_NONE;
		case (op)
			OP_LB, OP_LH, OP_LW: begin
				regWriteEn = BYTES_ALL; // sign extended in write-back
			end
			OP_LBU: begin
				regWriteEn = BYTES_ONE;
			end
			OP_LHU: begin
				regWriteEn = BYTES_HALF;
			end
			OP_SB, OP_SH, OP_SW: begin
				isStore = 1'b1;
				memWriteEn = BYTES_ALL; // lane select done in memory stage
			end
			default: begin
				hit = 1'b0;
			end
		endcase
	end

endmodule

// File: src/regimmDecode.sv
`timescale 1ns/100ps

module regimmDecode import ctrlPkg::*; (
	input  logic [4:0] rt,
	output logic       hit,
	output logic       rtRead,
	output logic       branchLink,
	output logic [2:0] condition,
	output logic       linkWrite
);

	// rt is a sub-opcode here, not a register
	always_comb begin
		hit = 1'b0;
		rtRead = 1'b0;
		branchLink = 1'b0;
		condition = 3'b000;
		linkWrite = 1'b0;
		case (rt)
			RT_BLTZ: begin
				hit = 1'b1;
				rtRead = 1'b1; // compare against r0
				condition = COND_LTZ;
			end
			RT_BGEZ: begin
				hit = 1'b1;
				condition = COND_GEZ;
			end
			RT_BGEZAL: begin
				hit = 1'b1;
				condition = COND_GEZ;
				branchLink = 1'b1;
				linkWrite = 1'b1; // return address to ra
			end
			default: begin
				hit = 1'b0;
			end
		endcase
	end

endmodule

// File: src/specialDecode.sv
`timescale 1ns/100ps

module specialDecode import ctrlPkg::*; (
	input  logic [5:0] func,
	output logic       hit,
	output logic       rsRead,
	output logic       overflowEn,
	output logic       aluShiftSel,
	output logic [3:0] aluOp,
	output logic       shiftAmtSrc,
	output logic [1:0] shiftOp
);

	always_comb begin
		hit = 1'b1;
		rsRead = 1'b0;
		overflowEn = 1'b0;
		aluShiftSel = 1'b0;
		aluOp = 4'b0000;
		shiftAmtSrc = 1'b0;
		shiftOp = 2'b00;
		case (func)
			FN_ADD, FN_SUB, FN_SUBU, FN_XOR, FN_SLTU: begin
				rsRead = 1'b1;
				aluShiftSel = 1'b1; // result from ALU
				case (func)
					FN_ADD: begin
						aluOp = ALU_ADD;
						overflowEn = 1'b1;
					end
					FN_SUB: begin
						aluOp = ALU_SUB;
						overflowEn = 1'b1;
					end
					FN_SUBU: aluOp = ALU_SUBU;
					FN_XOR:  aluOp = ALU_XOR;
					default: aluOp = ALU_SLTU;
				endcase
			end
			FN_SRAV: begin
				rsRead = 1'b1;
				shiftAmtSrc = 1'b1; // amount from rs
				shiftOp = SHIFT_SRA;
			end
			FN_ROTR: begin
				shiftOp = SHIFT_ROTR; // amount from shamt
			end
			default: begin
				hit = 1'b0;
			end
		endcase
	end

endmodule

// File: src/ctrlPkg.sv
package ctrlPkg;

	// one instruction word, seen as R-format or I-format
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] func;
		} rFormat;
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} iFormat;
	} instrWord_u;

	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_LB      = 6'b100000;
	localparam logic [5:0] OP_LH      = 6'b100001;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_LBU     = 6'b100100;
	localparam logic [5:0] OP_LHU     = 6'b100101;
	localparam logic [5:0] OP_SB      = 6'b101000;
	localparam logic [5:0] OP_SH      = 6'b101001;
	localparam logic [5:0] OP_SW      = 6'b101011;

	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_SLTU = 6'b101011;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_ROTR = 6'b000010; // shares func code with srl

	localparam logic [4:0] RT_BLTZ   = 5'd0;
	localparam logic [4:0] RT_BGEZ   = 5'd1;
	localparam logic [4:0] RT_BGEZAL = 5'd17;

	localparam logic [3:0] ALU_ADDU = 4'b0000;
	localparam logic [3:0] ALU_SUBU = 4'b0001; // also the branch compare
	localparam logic [3:0] ALU_SLT  = 4'b0101;
	localparam logic [3:0] ALU_SLTU = 4'b0111;
	localparam logic [3:0] ALU_XOR  = 4'b1001;
	localparam logic [3:0] ALU_ADD  = 4'b1110;
	localparam logic [3:0] ALU_SUB  = 4'b1111;

	localparam logic [2:0] COND_EQ  = 3'b001;
	localparam logic [2:0] COND_NE  = 3'b010;
	localparam logic [2:0] COND_GEZ = 3'b011;
	localparam logic [2:0] COND_GTZ = 3'b100;
	localparam logic [2:0] COND_LEZ = 3'b101;
	localparam logic [2:0] COND_LTZ = 3'b110;

	localparam logic [1:0] SHIFT_SRA  = 2'b10;
	localparam logic [1:0] SHIFT_ROTR = 2'b11;

	localparam logic [1:0] REGDST_RD = 2'b00;
	localparam logic [1:0] REGDST_RT = 2'b01;
	localparam logic [1:0] REGDST_RA = 2'b10; // link register r31

	localparam logic [1:0] EXT_SIGN  = 2'b00;
	localparam logic [1:0] EXT_ZERO  = 2'b01;
	localparam logic [1:0] EXT_UPPER = 2'b10;

	localparam logic [3:0] BYTES_ALL  = 4'b1111;
	localparam logic [3:0] BYTES_HALF = 4'b0011;
	localparam logic [3:0] BYTES_ONE  = 4'b0001;
	localparam logic [3:0] BYTES_NONE = 4'b0000;

endpackage
